//--- src/video_pkg.sv
// Shared video types and graphics ROM layout; map rows are 32 words wide, patterns 8 words per tile
package video_pkg;

    // Raster positions
    typedef logic [8:0] hpos_t;
    typedef logic [8:0] vpos_t;

    // Pixel and colour data
    typedef logic [3:0]  pixel_index_t;
    typedef logic [4:0]  colour_t;
    // Red in [14:10], green in [9:5], blue in [4:0]
    typedef logic [14:0] rgb555_t;

    // Graphics ROM bus, eight 4-bit pixels per word, leftmost in the top nibble
    typedef logic [15:0] rom_addr_t;
    typedef logic [31:0] rom_word_t;

    typedef enum logic [1:0] {
        IDLE,
        MAP_REQ,
        PAT_REQ,
        READY
    } fetch_state_t;

    // Tile map, 32 words per tile row, code in the low byte
    localparam rom_addr_t MAP_BASE = 16'h0000;
    // Patterns, one word per tile line
    localparam rom_addr_t PAT_BASE = 16'h1000;

endpackage

//--- src/video_timer.sv
// Raster timer; CEN_DIV must be at least 2 and H_TOTAL a multiple of 8, sync and blank decoded from counters
`timescale 1ns/1ps

module video_timer #(
    parameter int CEN_DIV   = 4,
    parameter int H_TOTAL   = 384,
    parameter int H_VISIBLE = 256,
    parameter int V_TOTAL   = 264,
    parameter int V_VISIBLE = 224
) (
    input  logic                clk,
    input  logic                rst,
    output logic                pxl_cen,
    output logic                group_start,
    output video_pkg::hpos_t    hdump,
    output video_pkg::vpos_t    vdump,
    output logic                LHBL,
    output logic                LVBL,
    output logic                HS,
    output logic                VS
);

    localparam int CW = $clog2(CEN_DIV);

    logic [CW-1:0] cen_cnt;

    // Pixel clock enable divider
    always_ff @(posedge clk) begin
        if (rst) begin
            cen_cnt <= '0;
        end else if (cen_cnt == CW'(CEN_DIV - 1)) begin
            cen_cnt <= '0;
        end else begin
            cen_cnt <= cen_cnt + 1'b1;
        end
    end

    assign pxl_cen = (cen_cnt == CW'(CEN_DIV - 1));

    // Raster counters
    always_ff @(posedge clk) begin
        if (rst) begin
            hdump <= '0;
            vdump <= '0;
        end else if (pxl_cen) begin
            if (hdump == video_pkg::hpos_t'(H_TOTAL - 1)) begin
                hdump <= '0;
                if (vdump == video_pkg::vpos_t'(V_TOTAL - 1)) begin
                    vdump <= '0;
                end else begin
                    vdump <= vdump + 1'b1;
                end
            end else begin
                hdump <= hdump + 1'b1;
            end
        end
    end

    // First pixel of each 8-pixel group
    assign group_start = pxl_cen && (hdump[2:0] == 3'd0);

    assign LHBL = (hdump < video_pkg::hpos_t'(H_VISIBLE));
    assign LVBL = (vdump < video_pkg::vpos_t'(V_VISIBLE));

    // Sync pulses sit a little after the active area
    assign HS = (hdump >= video_pkg::hpos_t'(H_VISIBLE + 8)) &&
                (hdump <  video_pkg::hpos_t'(H_VISIBLE + 16));
    assign VS = (vdump >= video_pkg::vpos_t'(V_VISIBLE + 2)) &&
                (vdump <  video_pkg::vpos_t'(V_VISIBLE + 4));

endmodule

//--- src/tile_fetch_fsm.sv
// Tile fetcher, Wishbone classic reads; a fetch still open at the next group start is abandoned
`timescale 1ns/1ps

module tile_fetch_fsm #(
    parameter int H_TOTAL = 384,
    parameter int V_TOTAL = 264
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    pxl_cen,
    input  logic                    group_start,
    input  video_pkg::hpos_t        hdump,
    input  video_pkg::vpos_t        vdump,
    output logic                    rom_cyc,
    output logic                    rom_stb,
    output video_pkg::rom_addr_t    rom_adr,
    input  video_pkg::rom_word_t    rom_dat,
    input  logic                    rom_ack,
    output video_pkg::rom_word_t    pat_word,
    output logic                    word_valid
);

    video_pkg::fetch_state_t state;

    video_pkg::hpos_t       nxt_col;
    video_pkg::vpos_t       nxt_line;
    video_pkg::hpos_t       fetch_col;
    video_pkg::vpos_t       fetch_line;
    logic [7:0]             tile_code;
    logic                   start_pend;
    logic                   last_group;
    video_pkg::rom_addr_t   map_adr;
    video_pkg::rom_addr_t   pat_adr;

    // Group shown next, wrapping onto the following line
    assign last_group = (hdump == video_pkg::hpos_t'(H_TOTAL - 8));

    always_comb begin
        if (last_group) begin
            nxt_col = '0;
            if (vdump == video_pkg::vpos_t'(V_TOTAL - 1)) begin
                nxt_line = '0;
            end else begin
                nxt_line = vdump + 1'b1;
            end
        end else begin
            nxt_col  = {3'd0, hdump[8:3]} + 9'd1;
            nxt_line = vdump;
        end
    end

    assign map_adr = video_pkg::MAP_BASE + {5'd0, fetch_line[8:3], 5'd0} + {7'd0, fetch_col};
    assign pat_adr = video_pkg::PAT_BASE + {5'd0, tile_code, 3'd0} + {13'd0, fetch_line[2:0]};

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= video_pkg::IDLE;
            rom_cyc    <= 1'b0;
            rom_stb    <= 1'b0;
            word_valid <= 1'b0;
            start_pend <= 1'b0;
        end else if (pxl_cen && group_start) begin
            // Drop any open cycle and restart on the new group
            state      <= video_pkg::IDLE;
            rom_cyc    <= 1'b0;
            rom_stb    <= 1'b0;
            word_valid <= 1'b0;
            start_pend <= 1'b1;
            fetch_col  <= nxt_col;
            fetch_line <= nxt_line;
        end else begin
            case (state)
                video_pkg::IDLE: begin
                    if (start_pend) begin
                        start_pend <= 1'b0;
                        rom_cyc    <= 1'b1;
                        rom_stb    <= 1'b1;
                        rom_adr    <= map_adr;
                        state      <= video_pkg::MAP_REQ;
                    end
                end
                video_pkg::MAP_REQ: begin
                    if (rom_ack) begin
                        tile_code <= rom_dat[7:0];
                        rom_cyc   <= 1'b0;
                        rom_stb   <= 1'b0;
                        state     <= video_pkg::PAT_REQ;
                    end
                end
                video_pkg::PAT_REQ: begin
                    // One idle clock on the bus before the pattern read
                    if (!rom_cyc) begin
                        rom_cyc <= 1'b1;
                        rom_stb <= 1'b1;
                        rom_adr <= pat_adr;
                    end else if (rom_ack) begin
                        pat_word   <= rom_dat;
                        word_valid <= 1'b1;
                        rom_cyc    <= 1'b0;
                        rom_stb    <= 1'b0;
                        state      <= video_pkg::READY;
                    end
                end
                default: begin
                    // Hold the word until the next group start
                end
            endcase
        end
    end

endmodule

//--- src/pixel_shifter.sv
// Pixel shifter; a word not ready at the group start is replaced by index 0 for the whole group
`timescale 1ns/1ps

module pixel_shifter (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        pxl_cen,
    input  logic                        group_start,
    input  video_pkg::rom_word_t        pat_word,
    input  logic                        word_valid,
    output video_pkg::pixel_index_t     pxl_index
);

    video_pkg::rom_word_t shift_reg;

    always_ff @(posedge clk) begin
        if (rst) begin
            shift_reg <= '0;
        end else if (pxl_cen) begin
            if (group_start) begin
                // Late fetch shows the background index
                shift_reg <= word_valid ? pat_word : '0;
            end else begin
                shift_reg <= {shift_reg[27:0], 4'd0};
            end
        end
    end

    // Leftmost pixel sits in the top nibble
    assign pxl_index = shift_reg[31:28];

endmodule

//--- src/palette_ram.sv
// RGB555 palette, 16 entries; Wishbone classic slave with one-clock ack, bit 15 reads as zero
`timescale 1ns/1ps

module palette_ram (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        pxl_cen,
    input  logic                        LHBL,
    input  logic                        LVBL,
    input  video_pkg::pixel_index_t     pxl_index,
    input  logic                        cpu_cyc,
    input  logic                        cpu_stb,
    input  logic                        cpu_we,
    input  logic [3:0]                  cpu_adr,
    input  logic [15:0]                 cpu_dat_w,
    output logic [15:0]                 cpu_dat_r,
    output logic                        cpu_ack,
    output video_pkg::colour_t          red,
    output video_pkg::colour_t          green,
    output video_pkg::colour_t          blue,
    output logic                        LHBL_dly,
    output logic                        LVBL_dly
);

    video_pkg::rgb555_t pal [16];
    video_pkg::rgb555_t lookup;
    logic               LHBL_d1;
    logic               LVBL_d1;
    logic               bus_req;

    // New request only when no ack is pending
    assign bus_req = cpu_cyc && cpu_stb && !cpu_ack;

    always_ff @(posedge clk) begin
        if (rst) begin
            cpu_ack <= 1'b0;
            for (int i = 0; i < 16; i++) begin
                pal[i] <= '0;
            end
        end else begin
            cpu_ack <= bus_req;
            if (bus_req && cpu_we) begin
                pal[cpu_adr] <= cpu_dat_w[14:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bus_req) begin
            cpu_dat_r <= {1'b0, pal[cpu_adr]};
        end
    end

    assign lookup = pal[pxl_index];

    // Two-enable delay on blanking to match the shifter and lookup stages
    always_ff @(posedge clk) begin
        if (rst) begin
            LHBL_d1  <= 1'b0;
            LVBL_d1  <= 1'b0;
            LHBL_dly <= 1'b0;
            LVBL_dly <= 1'b0;
            red      <= '0;
            green    <= '0;
            blue     <= '0;
        end else if (pxl_cen) begin
            LHBL_d1  <= LHBL;
            LVBL_d1  <= LVBL;
            LHBL_dly <= LHBL_d1;
            LVBL_dly <= LVBL_d1;
            if (LHBL_d1 && LVBL_d1) begin
                red   <= lookup[14:10];
                green <= lookup[9:5];
                blue  <= lookup[4:0];
            end else begin
                // Black during blanking
                red   <= '0;
                green <= '0;
                blue  <= '0;
            end
        end
    end

endmodule

//--- src/video_top.sv
// Tile video top level with one clock; timing parameters go unchanged to the timer and fetcher
`timescale 1ns/1ps

module video_top #(
    parameter int CEN_DIV   = 4,
    parameter int H_TOTAL   = 384,
    parameter int H_VISIBLE = 256,
    parameter int V_TOTAL   = 264,
    parameter int V_VISIBLE = 224
) (
    input  logic                    clk,
    input  logic                    rst,
    output logic                    pxl_cen,
    output logic                    LHBL_dly,
    output logic                    LVBL_dly,
    output logic                    HS,
    output logic                    VS,
    // Graphics ROM master
    output logic                    rom_cyc,
    output logic                    rom_stb,
    output video_pkg::rom_addr_t    rom_adr,
    input  video_pkg::rom_word_t    rom_dat,
    input  logic                    rom_ack,
    // Palette slave
    input  logic                    cpu_cyc,
    input  logic                    cpu_stb,
    input  logic                    cpu_we,
    input  logic [3:0]              cpu_adr,
    input  logic [15:0]             cpu_dat_w,
    output logic [15:0]             cpu_dat_r,
    output logic                    cpu_ack,
    // Colours
    output video_pkg::colour_t      red,
    output video_pkg::colour_t      green,
    output video_pkg::colour_t      blue
);

    logic                       group_start;
    logic                       LHBL;
    logic                       LVBL;
    logic                       word_valid;
    video_pkg::hpos_t           hdump;
    video_pkg::vpos_t           vdump;
    video_pkg::rom_word_t       pat_word;
    video_pkg::pixel_index_t    pxl_index;

    video_timer #(
        .CEN_DIV    ( CEN_DIV       ),
        .H_TOTAL    ( H_TOTAL       ),
        .H_VISIBLE  ( H_VISIBLE     ),
        .V_TOTAL    ( V_TOTAL       ),
        .V_VISIBLE  ( V_VISIBLE     )
    ) u_timer (
        .clk        ( clk           ),
        .rst        ( rst           ),
        .pxl_cen    ( pxl_cen       ),
        .group_start( group_start   ),
        .hdump      ( hdump         ),
        .vdump      ( vdump         ),
        .LHBL       ( LHBL          ),
        .LVBL       ( LVBL          ),
        .HS         ( HS            ),
        .VS         ( VS            )
    );

    tile_fetch_fsm #(
        .H_TOTAL    ( H_TOTAL       ),
        .V_TOTAL    ( V_TOTAL       )
    ) u_fetch (
        .clk        ( clk           ),
        .rst        ( rst           ),
        .pxl_cen    ( pxl_cen       ),
        .group_start( group_start   ),
        .hdump      ( hdump         ),
        .vdump      ( vdump         ),
        .rom_cyc    ( rom_cyc       ),
        .rom_stb    ( rom_stb       ),
        .rom_adr    ( rom_adr       ),
        .rom_dat    ( rom_dat       ),
        .rom_ack    ( rom_ack       ),
        .pat_word   ( pat_word      ),
        .word_valid ( word_valid    )
    );

    pixel_shifter u_shifter (
        .clk        ( clk           ),
        .rst        ( rst           ),
        .pxl_cen    ( pxl_cen       ),
        .group_start( group_start   ),
        .pat_word   ( pat_word      ),
        .word_valid ( word_valid    ),
        .pxl_index  ( pxl_index     )
    );

    palette_ram u_palette (
        .clk        ( clk           ),
        .rst        ( rst           ),
        .pxl_cen    ( pxl_cen       ),
        .LHBL       ( LHBL          ),
        .LVBL       ( LVBL          ),
        .pxl_index  ( pxl_index     ),
        .cpu_cyc    ( cpu_cyc       ),
        .cpu_stb    ( cpu_stb       ),
        .cpu_we     ( cpu_we        ),
        .cpu_adr    ( cpu_adr       ),
        .cpu_dat_w  ( cpu_dat_w     ),
        .cpu_dat_r  ( cpu_dat_r     ),
        .cpu_ack    ( cpu_ack       ),
        .red        ( red           ),
        .green      ( green         ),
        .blue       ( blue          ),
        .LHBL_dly   ( LHBL_dly      ),
        .LVBL_dly   ( LVBL_dly      )
    );

endmodule

//--- test/gfx_rom_model.sv
// Graphics ROM model for the testbench; 8192 words filled by the testbench, ack after 1 to 3 clocks
`timescale 1ns/1ps

module gfx_rom_model (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    rom_cyc,
    input  logic                    rom_stb,
    input  video_pkg::rom_addr_t    rom_adr,
    output video_pkg::rom_word_t    rom_dat,
    output logic                    rom_ack
);

    video_pkg::rom_word_t mem [8192];

    // Ack delay in clocks, used in turn
    logic [1:0] ack_delay [4] = '{2'd1, 2'd3, 2'd2, 2'd1};

    logic [1:0]             dly_sel = 2'd0;
    logic [1:0]             wait_cnt = 2'd0;
    logic                   ack_q = 1'b0;
    video_pkg::rom_word_t   dat_q = '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            ack_q    <= 1'b0;
            dat_q    <= '0;
            wait_cnt <= '0;
            dly_sel  <= '0;
        end else if (rom_cyc && rom_stb && !ack_q) begin
            if (wait_cnt == ack_delay[dly_sel] - 2'd1) begin
                ack_q    <= 1'b1;
                dat_q    <= mem[rom_adr[12:0]];
                wait_cnt <= '0;
                dly_sel  <= dly_sel + 2'd1;
            end else begin
                wait_cnt <= wait_cnt + 2'd1;
            end
        end else begin
            // Abandoned request starts its count again
            ack_q    <= 1'b0;
            wait_cnt <= '0;
        end
    end

    assign rom_ack = ack_q;
    assign rom_dat = dat_q;

endmodule

//--- test/video_tb.sv
// Testbench for video_top on a 96x40 raster; first frame after reset is skipped, stops at the first error
`timescale 1ns/1ps

module video_tb;

    localparam int CEN_DIV   = 4;
    localparam int H_TOTAL   = 96;
    localparam int H_VISIBLE = 64;
    localparam int V_TOTAL   = 40;
    localparam int V_VISIBLE = 24;
    localparam int MAP_END   = int'(video_pkg::MAP_BASE) + 32 * ((V_TOTAL + 7) / 8);
    localparam int PAT_END   = int'(video_pkg::PAT_BASE) + 256 * 8;

    logic                       clk;
    logic                       rst;
    logic                       pxl_cen;
    logic                       LHBL_dly;
    logic                       LVBL_dly;
    logic                       HS;
    logic                       VS;
    logic                       rom_cyc;
    logic                       rom_stb;
    video_pkg::rom_addr_t       rom_adr;
    video_pkg::rom_word_t       rom_dat;
    logic                       rom_ack;
    logic                       cpu_cyc;
    logic                       cpu_stb;
    logic                       cpu_we;
    logic [3:0]                 cpu_adr;
    logic [15:0]                cpu_dat_w;
    logic [15:0]                cpu_dat_r;
    logic                       cpu_ack;
    video_pkg::colour_t         red;
    video_pkg::colour_t         green;
    video_pkg::colour_t         blue;

    // Reference copies of ROM and palette
    video_pkg::rom_word_t       ref_mem [8192];
    video_pkg::rgb555_t         pal_ref [16];

    // Entry, write data, expected readback
    logic [35:0] pal_tab [18] = '{
        {4'h0, 16'hFC21, 16'h7C21},
        {4'h1, 16'h0001, 16'h0001},
        {4'h2, 16'h0020, 16'h0020},
        {4'h3, 16'h0400, 16'h0400},
        {4'h4, 16'hFFFF, 16'h7FFF},
        {4'h5, 16'h1234, 16'h1234},
        {4'h6, 16'h8003, 16'h0003},
        {4'h7, 16'h2A55, 16'h2A55},
        {4'h8, 16'h5AA5, 16'h5AA5},
        {4'h9, 16'hC3C3, 16'h43C3},
        {4'hA, 16'h0F0F, 16'h0F0F},
        {4'hB, 16'h7001, 16'h7001},
        {4'hC, 16'h9248, 16'h1248},
        {4'hD, 16'h6DB6, 16'h6DB6},
        {4'hE, 16'hB5AD, 16'h35AD},
        {4'hF, 16'h4210, 16'h4210},
        {4'h0, 16'h03E0, 16'h03E0},
        {4'h5, 16'hFFE0, 16'h7FE0}
    };

    int x;
    int y;
    int act_lines;
    int hs_pix;
    int lines_vs;
    int frames = 0;
    int vs_checks = 0;
    logic hs_seen = 1'b0;
    logic vs_seen = 1'b0;
    logic prev_lhbl;
    logic prev_lvbl;
    logic prev_hs;
    logic prev_vs;
    video_pkg::pixel_index_t idx;

    // ROM bus monitor state
    logic wait_ack;
    logic mon_hs;
    int   rom_reads;
    int   mon_lines;

    video_top #(
        .CEN_DIV    ( CEN_DIV   ),
        .H_TOTAL    ( H_TOTAL   ),
        .H_VISIBLE  ( H_VISIBLE ),
        .V_TOTAL    ( V_TOTAL   ),
        .V_VISIBLE  ( V_VISIBLE )
    ) dut (
        .clk        ( clk       ),
        .rst        ( rst       ),
        .pxl_cen    ( pxl_cen   ),
        .LHBL_dly   ( LHBL_dly  ),
        .LVBL_dly   ( LVBL_dly  ),
        .HS         ( HS        ),
        .VS         ( VS        ),
        .rom_cyc    ( rom_cyc   ),
        .rom_stb    ( rom_stb   ),
        .rom_adr    ( rom_adr   ),
        .rom_dat    ( rom_dat   ),
        .rom_ack    ( rom_ack   ),
        .cpu_cyc    ( cpu_cyc   ),
        .cpu_stb    ( cpu_stb   ),
        .cpu_we     ( cpu_we    ),
        .cpu_adr    ( cpu_adr   ),
        .cpu_dat_w  ( cpu_dat_w ),
        .cpu_dat_r  ( cpu_dat_r ),
        .cpu_ack    ( cpu_ack   ),
        .red        ( red       ),
        .green      ( green     ),
        .blue       ( blue      )
    );

    gfx_rom_model rom (
        .clk        ( clk       ),
        .rst        ( rst       ),
        .rom_cyc    ( rom_cyc   ),
        .rom_stb    ( rom_stb   ),
        .rom_adr    ( rom_adr   ),
        .rom_dat    ( rom_dat   ),
        .rom_ack    ( rom_ack   )
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Pixel index from the map and pattern layout
    function automatic video_pkg::pixel_index_t ref_index(input int px, input int py);
        logic [12:0] a;
        logic [31:0] code_w;
        logic [31:0] pat_w;
        logic [4:0]  sh;
        a = 13'(int'(video_pkg::MAP_BASE) + (py / 8) * 32 + px / 8);
        code_w = ref_mem[a];
        a = 13'(int'(video_pkg::PAT_BASE) + int'(code_w[7:0]) * 8 + py % 8);
        pat_w = ref_mem[a];
        sh = 5'(28 - 4 * (px % 8));
        return pat_w[sh +: 4];
    endfunction

    task automatic stop_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped after an error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (expected === actual) else begin
            $display("error: %s expected %0h actual %0h", name, expected, actual);
            stop_run();
        end
    endtask

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic next_pixel();
        int n;
        n = 0;
        do begin
            tick();
            n++;
        end while (!pxl_cen && n <= 2 * CEN_DIV);
        assert (pxl_cen) else begin
            $display("timeout waiting for pxl_cen");
            stop_run();
        end
    endtask

    task automatic cpu_access(input logic we, input logic [3:0] adr, input logic [15:0] wdata,
                              output logic [15:0] rdata);
        int n;
        cpu_cyc   = 1'b1;
        cpu_stb   = 1'b1;
        cpu_we    = we;
        cpu_adr   = adr;
        cpu_dat_w = wdata;
        n = 0;
        do begin
            tick();
            n++;
        end while (!cpu_ack && n < 16);
        assert (cpu_ack) else begin
            $display("timeout waiting for cpu_ack on palette entry %0d", adr);
            stop_run();
        end
        check_value("cpu_ack latency", 32'd1, 32'(n));
        rdata   = cpu_dat_r;
        cpu_cyc = 1'b0;
        cpu_stb = 1'b0;
        cpu_we  = 1'b0;
        tick();
    endtask

    // Ends on the first pixel of a frame that follows a vertical blank
    task automatic wait_frame_start();
        int n;
        next_pixel();
        n = 0;
        while (LVBL_dly && n < 2 * H_TOTAL * V_TOTAL) begin
            next_pixel();
            n++;
        end
        assert (!LVBL_dly) else begin
            $display("vertical blank never started");
            stop_run();
        end
        n = 0;
        while (!LVBL_dly && n < 2 * H_TOTAL * V_TOTAL) begin
            next_pixel();
            n++;
        end
        assert (LVBL_dly) else begin
            $display("vertical blank never ended");
            stop_run();
        end
    endtask

    // ROM bus protocol and reads per line
    always @(posedge clk) begin
        if (rst) begin
            wait_ack  = 1'b0;
            mon_hs    = 1'b0;
            rom_reads = 0;
            mon_lines = 0;
        end else begin
            if (wait_ack) begin
                assert (rom_cyc && rom_stb) else begin
                    $display("rom_stb dropped before rom_ack");
                    stop_run();
                end
            end
            if (rom_stb) begin
                assert (int'(rom_adr) < MAP_END || (int'(rom_adr) >= int'(video_pkg::PAT_BASE)
                        && int'(rom_adr) < PAT_END)) else begin
                    $display("rom_adr %h lies outside the map and pattern areas", rom_adr);
                    stop_run();
                end
            end
            if (rom_stb && rom_ack) begin
                rom_reads++;
            end
            if (HS && !mon_hs) begin
                if (mon_lines > 0) begin
                    check_value("rom reads per line", 32'(H_TOTAL / 8 * 2), 32'(rom_reads));
                end
                mon_lines++;
                rom_reads = 0;
            end
            mon_hs   = HS;
            wait_ack = rom_stb && !rom_ack;
        end
    end

    initial begin
        logic [31:0] seed;
        logic [12:0] a;
        logic [4:0]  t;
        logic [35:0] row;
        logic [15:0] rd;
        rst       = 1'b1;
        cpu_cyc   = 1'b0;
        cpu_stb   = 1'b0;
        cpu_we    = 1'b0;
        cpu_adr   = '0;
        cpu_dat_w = '0;
        seed = 32'h777e9941;
        a = '0;
        repeat (8192) begin
            seed = lcg(seed);
            ref_mem[a] = seed;
            rom.mem[a] = seed;
            a = a + 13'd1;
        end
        repeat (3) tick();
        rst = 1'b0;
        check_value("flags after reset", 32'd0, 32'({HS, VS, LHBL_dly, LVBL_dly, rom_cyc, cpu_ack}));
        check_value("colour after reset", 32'd0, 32'({red, green, blue}));

        // Palette writes, each read back at once
        t = '0;
        repeat (18) begin
            row = pal_tab[t];
            cpu_access(1'b1, row[35:32], row[31:16], rd);
            cpu_access(1'b0, row[35:32], 16'h0000, rd);
            check_value($sformatf("palette readback entry %0d", row[35:32]), 32'(row[15:0]), 32'(rd));
            pal_ref[row[35:32]] = row[14:0];
            t = t + 5'd1;
        end

        // Two full frames, one sample per pixel
        wait_frame_start();
        prev_lhbl = 1'b0;
        prev_lvbl = 1'b0;
        prev_hs   = HS;
        prev_vs   = VS;
        repeat (2 * H_TOTAL * V_TOTAL) begin
            if (LVBL_dly && !prev_lvbl) begin
                y = -1;
                act_lines = 0;
            end
            if (!LVBL_dly && prev_lvbl) begin
                check_value("visible lines per frame", 32'(V_VISIBLE), 32'(act_lines));
                frames++;
            end
            if (LHBL_dly && !prev_lhbl) begin
                x = 0;
                if (LVBL_dly) begin
                    y++;
                    act_lines++;
                end
            end
            if (!LHBL_dly && prev_lhbl && LVBL_dly) begin
                check_value("visible pixels per line", 32'(H_VISIBLE), 32'(x));
            end
            if (LHBL_dly && LVBL_dly) begin
                idx = ref_index(x, y);
                check_value($sformatf("pixel colour x %0d y %0d", x, y), 32'(pal_ref[idx]),
                            32'({red, green, blue}));
                x++;
            end else begin
                check_value("colour during blanking", 32'd0, 32'({red, green, blue}));
            end
            if (HS && !prev_hs) begin
                if (hs_seen) begin
                    check_value("pxl_cen pulses per line", 32'(H_TOTAL), 32'(hs_pix));
                end
                hs_seen = 1'b1;
                hs_pix  = 0;
                lines_vs++;
            end
            if (VS && !prev_vs) begin
                if (vs_seen) begin
                    check_value("lines per frame", 32'(V_TOTAL), 32'(lines_vs));
                    vs_checks++;
                end
                vs_seen  = 1'b1;
                lines_vs = 0;
            end
            hs_pix++;
            prev_lhbl = LHBL_dly;
            prev_lvbl = LVBL_dly;
            prev_hs   = HS;
            prev_vs   = VS;
            next_pixel();
        end

        if (frames == 2 && vs_checks == 1 && mon_lines > V_TOTAL) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            $display("raster checks incomplete: frames %0d, vsync periods %0d, rom lines %0d",
                     frames, vs_checks, mon_lines);
            stop_run();
        end
    end

endmodule

//--- video.f
src/video_pkg.sv
src/video_timer.sv
src/tile_fetch_fsm.sv
src/pixel_shifter.sv
src/palette_ram.sv
src/video_top.sv
test/gfx_rom_model.sv
test/video_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the video testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
    --top-module video_tb -Mdir obj_dir -f video.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vvideo_tb > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "TEST FAILED" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
if ! grep -q "TEST PASSED" "$LOG"; then
    echo "Simulation ended without a result"
    exit 1
fi
exit 0
